//--- rtl/lane_defs.svh
// ========================================
// Lane switch sizing macros
// Lane count, FIFO depth and payload width
// ========================================

`ifndef LANE_DEFS_SVH
`define LANE_DEFS_SVH

// Number of independent lanes
`define LANE_COUNT 4

// Slots per lane FIFO
// Must be a power of two and one slot always stays free
`define LANE_DEPTH 4

// Payload width in bits
`define DATA_WIDTH 8

`endif

//--- rtl/lane_pkg.sv
// ========================================
// Lane switch shared types
// ========================================

`default_nettype none

`include "lane_defs.svh"

package lane_pkg;

    // Payload carried through every lane
    typedef logic [`DATA_WIDTH-1:0] data_t;

    // Lane number as seen on both handshakes
    typedef logic [$clog2(`LANE_COUNT)-1:0] lane_id_t;

    // Output side handshake sequencing
    typedef enum logic [1:0] {
        // Looking for a non-empty lane
        COLLECT_IDLE,
        // out_req high and waiting for out_ack
        COLLECT_REQ,
        // out_req low and waiting for out_ack to drop
        COLLECT_RELEASE
    } collect_state_t;

endpackage : lane_pkg

`default_nettype wire

//--- rtl/lane_fifo_if.sv
// ========================================
// Push and pop bundle of one lane FIFO
// ========================================

`timescale 1ns/1ps
`default_nettype none

interface lane_fifo_if;
    import lane_pkg::*;

    // Write side
    logic  push;
    data_t push_data;
    logic  full;

    // Read side
    logic  pop;
    data_t pop_data;
    logic  empty;

    // Dispatcher pushes only when full is low
    modport writer (output push, output push_data, input full);

    // Collector pops only when empty is low and reads the head
    modport reader (output pop, input pop_data, input empty);

    // Storage side owns the flags and the head data
    modport fifo (
        input  push, input  push_data, input  pop,
        output pop_data, output full, output empty
    );

endinterface : lane_fifo_if

`default_nettype wire

//--- rtl/fifo.sv
// ========================================
// Lane FIFO
// Circular buffer with head always visible
// ========================================

`timescale 1ns/1ps
`default_nettype none

`include "lane_defs.svh"

module fifo #(
    parameter int FIFO_DEPTH = `LANE_DEPTH
) (
    input  logic       clk,
    input  logic       reset,
    lane_fifo_if.fifo  bus
);
    import lane_pkg::*;

    // Pointer width for a power-of-two depth
    localparam int PTR_W = $clog2(FIFO_DEPTH);

    // Storage array
    data_t mem [FIFO_DEPTH];

    // Read and write pointers
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] wr_ptr;

    // Pointer increments wrap naturally at the depth
    logic [PTR_W-1:0] rd_ptr_inc;
    logic [PTR_W-1:0] wr_ptr_inc;

    assign rd_ptr_inc = rd_ptr + 1'b1;
    assign wr_ptr_inc = wr_ptr + 1'b1;

    // Equal pointers mean nothing stored
    assign bus.empty = (wr_ptr == rd_ptr);

    // One slot kept free so full never aliases empty
    assign bus.full = (wr_ptr_inc == rd_ptr);

    // Head entry shown continuously
    assign bus.pop_data = mem[rd_ptr];

    // Payload storage without reset
    always_ff @(posedge clk) begin
        if (bus.push) begin
            mem[wr_ptr] <= bus.push_data;
        end
    end

    // Pointer update
    always_ff @(posedge clk) begin
        if (reset) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
        end else begin
            if (bus.push) begin
                wr_ptr <= wr_ptr_inc;
            end
            // Head moves on the edge after the pop
            if (bus.pop) begin
                rd_ptr <= rd_ptr_inc;
            end
        end
    end

    // Writer must honour full
    a_no_push_when_full : assert property (
        @(posedge clk) disable iff (reset) !(bus.push && bus.full)
    ) else $error("push while full");

    // Reader must honour empty
    a_no_pop_when_empty : assert property (
        @(posedge clk) disable iff (reset) !(bus.pop && bus.empty)
    ) else $error("pop while empty");

endmodule : fifo

`default_nettype wire

//--- rtl/lane_dispatch.sv
// ========================================
// Lane dispatcher
// Input req/ack handshake into lane FIFOs
// ========================================

`timescale 1ns/1ps
`default_nettype none

`include "lane_defs.svh"

module lane_dispatch (
    input  logic               clk,
    input  logic               reset,
    input  logic               in_req,
    input  lane_pkg::lane_id_t in_lane,
    input  lane_pkg::data_t    in_data,
    output logic               in_ack,
    lane_fifo_if.writer        lanes [`LANE_COUNT]
);
    import lane_pkg::*;

    // Full flags gathered from every lane
    logic [`LANE_COUNT-1:0] lane_full;

    // Item of the current request already pushed
    logic pushed;

    // Single push strobe for the addressed lane
    logic push_en;

    // Push once per request when the target lane has room
    assign push_en = in_req && !pushed && !lane_full[in_lane];

    // Per-lane decode and flag collection
    for (genvar g = 0; g < `LANE_COUNT; g++) begin : g_lane
        assign lanes[g].push      = push_en && (in_lane == lane_id_t'(g));
        assign lanes[g].push_data = in_data;
        assign lane_full[g]       = lanes[g].full;
    end

    // Handshake state
    // Set on the push edge so in_ack follows one cycle after in_req
    always_ff @(posedge clk) begin
        if (reset) begin
            pushed <= 1'b0;
        end else if (!in_req) begin
            // Release phase once the producer drops in_req
            pushed <= 1'b0;
        end else if (push_en) begin
            pushed <= 1'b1;
        end
    end

    // Ack mirrors the pushed flag
    assign in_ack = pushed;

    // Ack may only rise in answer to a live request
    a_ack_needs_req : assert property (
        @(posedge clk) disable iff (reset) $rose(in_ack) |-> in_req
    ) else $error("in_ack rose without in_req");

endmodule : lane_dispatch

`default_nettype wire

//--- rtl/lane_collect.sv
// ========================================
// Lane collector
// Round-robin drain onto the output handshake
// ========================================

`timescale 1ns/1ps
`default_nettype none

`include "lane_defs.svh"

module lane_collect (
    input  logic               clk,
    input  logic               reset,
    lane_fifo_if.reader        lanes [`LANE_COUNT],
    output logic               out_req,
    output lane_pkg::lane_id_t out_lane,
    output lane_pkg::data_t    out_data,
    input  logic               out_ack
);
    import lane_pkg::*;

    collect_state_t state;

    // Last lane handed out
    lane_id_t last_lane;

    // Flags and head data gathered from every lane
    logic [`LANE_COUNT-1:0] lane_empty;
    data_t                  lane_data [`LANE_COUNT];

    // Round-robin pick
    lane_id_t pick;
    logic     found;

    // Pop strobe for the picked lane
    logic pop_en;

    for (genvar g = 0; g < `LANE_COUNT; g++) begin : g_lane
        assign lane_empty[g] = lanes[g].empty;
        assign lane_data[g]  = lanes[g].pop_data;
        assign lanes[g].pop  = pop_en && (pick == lane_id_t'(g));
    end

    // First non-empty lane cyclically after the last one served
    always_comb begin
        int idx;
        pick  = last_lane;
        found = 1'b0;
        for (int k = 1; k <= `LANE_COUNT; k++) begin
            idx = (int'(last_lane) + k) % `LANE_COUNT;
            if (!found && !lane_empty[idx]) begin
                pick  = lane_id_t'(idx);
                found = 1'b1;
            end
        end
    end

    // Pop only from idle
    assign pop_en = (state == COLLECT_IDLE) && found;

    // Request is high for the whole REQ phase
    assign out_req = (state == COLLECT_REQ);

    // Collector FSM
    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= COLLECT_IDLE;
            // Lane 0 comes first after reset
            last_lane <= lane_id_t'(`LANE_COUNT - 1);
        end else begin
            case (state)
                COLLECT_IDLE: begin
                    if (found) begin
                        state     <= COLLECT_REQ;
                        last_lane <= pick;
                    end
                end
                COLLECT_REQ: begin
                    // Held here under back-pressure
                    if (out_ack) state <= COLLECT_RELEASE;
                end
                COLLECT_RELEASE: begin
                    if (!out_ack) state <= COLLECT_IDLE;
                end
                default: state <= COLLECT_IDLE;
            endcase
        end
    end

    // Output payload captured with the pop
    always_ff @(posedge clk) begin
        if (pop_en) begin
            out_data <= lane_data[pick];
            out_lane <= pick;
        end
    end

    // Payload stays put for as long as the request is up
    a_out_stable : assert property (
        @(posedge clk) disable iff (reset)
        (out_req && $past(out_req)) |-> ($stable(out_lane) && $stable(out_data))
    ) else $error("out_lane or out_data changed while out_req high");

endmodule : lane_collect

`default_nettype wire

//--- rtl/lane_switch_top.sv
// ========================================
// Lane switch top level
// Dispatcher, lane FIFOs and collector
// ========================================

`timescale 1ns/1ps
`default_nettype none

`include "lane_defs.svh"

module lane_switch_top (
    input  logic               clk,
    input  logic               reset,

    // Producer side
    input  logic               in_req,
    input  lane_pkg::lane_id_t in_lane,
    input  lane_pkg::data_t    in_data,
    output logic               in_ack,

    // Consumer side
    output logic               out_req,
    output lane_pkg::lane_id_t out_lane,
    output lane_pkg::data_t    out_data,
    input  logic               out_ack
);

    // One FIFO bundle per lane
    lane_fifo_if lane_bus [`LANE_COUNT] ();

    // Input handshake into the lanes
    lane_dispatch i_lane_dispatch (
        .clk     (clk),
        .reset   (reset),
        .in_req  (in_req),
        .in_lane (in_lane),
        .in_data (in_data),
        .in_ack  (in_ack),
        .lanes   (lane_bus)
    );

    // Lane storage
    for (genvar g = 0; g < `LANE_COUNT; g++) begin : g_lane
        fifo #(
            .FIFO_DEPTH (`LANE_DEPTH)
        ) i_fifo (
            .clk   (clk),
            .reset (reset),
            .bus   (lane_bus[g])
        );
    end

    // Round-robin drain to the output handshake
    lane_collect i_lane_collect (
        .clk      (clk),
        .reset    (reset),
        .lanes    (lane_bus),
        .out_req  (out_req),
        .out_lane (out_lane),
        .out_data (out_data),
        .out_ack  (out_ack)
    );

endmodule : lane_switch_top

`default_nettype wire

//--- sim/lane_switch_tb.sv
// ========================================
// Lane switch testbench
// Queue model, handshake driver and checks
// ========================================

`timescale 1ns/1ps
`default_nettype none

`include "lane_defs.svh"

module lane_switch_tb;
    import lane_pkg::*;

    logic     clk = 1'b0;
    logic     reset = 1'b1;
    logic     in_req = 1'b0;
    logic     out_ack = 1'b0;
    lane_id_t in_lane = '0;
    data_t    in_data = '0;
    logic     in_ack, out_req;
    lane_id_t out_lane;
    data_t    out_data;

    // Per-lane queues of accepted items, oldest at the front
    data_t    model_q [`LANE_COUNT][$];
    lane_id_t last_served;
    logic     prev_req = 1'b0;
    logic     hold_out = 1'b0;
    logic     rr_check = 1'b0;
    integer   seed = 32'hf798;
    int       ack_wait = 0;
    int       cycles = 0;
    int       deliveries = 0;

    lane_switch_top i_lane_switch_top (.*);

    always #2 clk = ~clk;

    // Whole run needs about 2500 cycles
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= 4000) fail_stop("timeout, the DUT stopped making progress");
    end

    task automatic fail_stop(input string reason);
        $display("%s", reason);
        $display("test failed");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_data(input string name, input data_t got, input data_t exp);
        if (got !== exp)
            fail_stop($sformatf("CHECK FAILED %s got 0x%h expected 0x%h", name, got, exp));
    endtask

    task automatic check_lane(input string name, input lane_id_t got, input lane_id_t exp);
        if (got !== exp)
            fail_stop($sformatf("CHECK FAILED %s got 0x%h expected 0x%h", name, got, exp));
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp)
            fail_stop($sformatf("CHECK FAILED %s got 0x%h expected 0x%h", name, got, exp));
    endtask

    // Lowest busy lane above the last one served, else the lowest busy lane
    function automatic lane_id_t expected_lane(input lane_id_t last,
                                               input logic [`LANE_COUNT-1:0] busy);
        int first_busy;
        int after_last;
        first_busy = -1;
        after_last = -1;
        // Descending scan leaves the lowest match in each variable
        for (int l = `LANE_COUNT - 1; l >= 0; l--) begin
            if (busy[l]) begin
                first_busy = l;
                if (l > int'(last)) after_last = l;
            end
        end
        if (after_last >= 0) return lane_id_t'(after_last);
        if (first_busy >= 0) return lane_id_t'(first_busy);
        return last;
    endfunction

    // Consumer with a random ack delay, stalled while hold_out is set
    always @(posedge clk) begin
        if (reset) begin
            out_ack  <= 1'b0;
            ack_wait <= 0;
        end else if (out_ack) begin
            if (!out_req) out_ack <= 1'b0;
        end else if (out_req && !hold_out) begin
            if (ack_wait == 0) begin
                out_ack  <= 1'b1;
                ack_wait <= $random(seed) & 3;
            end else begin
                ack_wait <= ack_wait - 1;
            end
        end
    end

    // Each rising out_req is one delivery
    always @(posedge clk) begin
        logic [`LANE_COUNT-1:0] busy;
        prev_req <= out_req;
        if (!reset && out_req && !prev_req) begin
            for (int l = 0; l < `LANE_COUNT; l++) busy[l] = (model_q[l].size() != 0);
            if (rr_check) check_lane("out_lane", out_lane, expected_lane(last_served, busy));
            if (!busy[out_lane]) fail_stop("out_req rose for a lane with nothing outstanding");
            check_data("out_data", out_data, model_q[out_lane].pop_front());
            last_served = out_lane;
            deliveries++;
        end
    end

    // Producer side, returns edges from in_req driven to in_ack seen
    task automatic send_item(input lane_id_t lane, input data_t data, output int waited);
        @(posedge clk);
        in_req  <= 1'b1;
        in_lane <= lane;
        in_data <= data;
        waited = 0;
        do begin
            @(posedge clk);
            waited++;
        end while (!in_ack);
        model_q[lane].push_back(data);
        in_req <= 1'b0;
        do @(posedge clk); while (in_ack);
    endtask

    task automatic wait_idle();
        int pending;
        do begin
            @(posedge clk);
            pending = 0;
            for (int l = 0; l < `LANE_COUNT; l++) pending += model_q[l].size();
        end while (pending != 0 || out_req || out_ack);
    endtask

    initial begin
        int waited;
        int rnd;
        int base;
        last_served = lane_id_t'(`LANE_COUNT - 1);
        repeat (8) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);
        // Idle after reset, then a single item through lane 1
        check_bit("in_ack", in_ack, 1'b0);
        check_bit("out_req", out_req, 1'b0);
        rr_check <= 1'b1;
        send_item(lane_id_t'(1), 8'h5a, waited);
        if (waited > 2) fail_stop("in_ack came later than one cycle after in_req");
        wait_idle();
        rr_check <= 1'b0;
        // Random traffic with random delays on both sides
        for (int i = 0; i < 200; i++) begin
            rnd = $random(seed);
            repeat (rnd[1:0]) @(posedge clk);
            send_item(lane_id_t'(rnd >> 8), data_t'(rnd >> 16), waited);
        end
        wait_idle();
        // Back-pressure on lane 2, fifth item must wait
        hold_out <= 1'b1;
        for (int i = 0; i < 4; i++) send_item(lane_id_t'(2), data_t'(8'h20 + i), waited);
        fork
            send_item(lane_id_t'(2), 8'h24, waited);
            begin
                repeat (20) begin
                    @(posedge clk);
                    check_bit("in_ack", in_ack, 1'b0);
                end
                hold_out <= 1'b0;
            end
        join
        wait_idle();
        // Round robin over preloaded lanes
        hold_out <= 1'b1;
        rr_check <= 1'b1;
        for (int r = 0; r < 3; r++)
            for (int l = 0; l < `LANE_COUNT; l++)
                send_item(lane_id_t'(l), data_t'(16 * l + r), waited);
        hold_out <= 1'b0;
        wait_idle();
        rr_check <= 1'b0;
        // Lane 0 blocked, no traffic to the others
        hold_out <= 1'b1;
        for (int i = 0; i < 4; i++) send_item(lane_id_t'(0), data_t'(8'h40 + i), waited);
        fork
            send_item(lane_id_t'(0), 8'h44, waited);
            begin
                repeat (10) @(posedge clk);
                hold_out <= 1'b0;
            end
        join
        wait_idle();
        base = deliveries;
        repeat (50) @(posedge clk);
        if (deliveries != base) fail_stop("extra delivery after all lanes drained");
        check_bit("out_req", out_req, 1'b0);
        $display("test passed");
        $finish;
    end

endmodule : lane_switch_tb

`default_nettype wire

//--- sim.f
+incdir+rtl
rtl/lane_pkg.sv
rtl/lane_fifo_if.sv
rtl/fifo.sv
rtl/lane_dispatch.sv
rtl/lane_collect.sv
rtl/lane_switch_top.sv
sim/lane_switch_tb.sv

//--- Makefile
# Verilator flow for the lane switch
SIM        ?= verilator
SIM_FLAGS  ?= --binary --timing --assert
LINT_FLAGS ?= --lint-only --timing -Wall
TOP        ?= lane_switch_tb
FILELIST   ?= sim.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(SIM) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "test failed" $(LOG); then echo "simulation FAILED"; exit 1; fi
	@grep -q "test passed" $(LOG) || (echo "simulation did not finish"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
